/* Bender.yml */
package:
  name: vcache_tile

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - vc_mc_pkg.sv
      - vc_wh_pkg.sv
      - vc_tile_if.sv
      - vc_link_to_cache.sv
      - vc_cache.sv
      - vc_dma_to_wh.sv
      - vcache_tile.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_vcache_tile.sv

/* tb_vcache_tile.sv */
`timescale 1ns/1ps
`include "vc_consts.svh"

module tb_vcache_tile
  import vc_mc_pkg::*, vc_wh_pkg::*;
();

  // directed requests plus the random run
  localparam int NUM_REQS = 211;
  localparam int LIMIT_CYCLES = NUM_REQS * 60 + 40;
  localparam logic [3:0] MY_X = 4'h5;
  localparam logic [3:0] MY_Y = 4'h9;

  logic        clk_i;
  logic        rst_n_i;
  logic        rst_n_o;
  logic        req_v_i;
  mc_op_e      req_op_i;
  logic [11:0] req_addr_i;
  logic [31:0] req_data_i;
  logic        req_ready_o;
  logic        resp_v_o;
  logic [31:0] resp_data_o;
  logic        resp_ready_i;
  logic        wh_v_o;
  logic [31:0] wh_flit_o;
  logic        wh_ready_i;
  logic        wh_v_i;
  logic [31:0] wh_flit_i;
  logic        wh_ready_o;
  logic [3:0]  global_x_i;
  logic [3:0]  global_y_i;
  logic [3:0]  global_x_o;
  logic [3:0]  global_y_o;

  logic [31:0] golden [4096];
  logic [31:0] mem [4096];
  logic [31:0] exp_q [$];
  logic [31:0] reply_q [$];
  logic [31:0] exp_word;
  wh_flit_u    in_flit;
  wh_flit_u    reply_flit;
  string       cur_test;
  int unsigned seed;
  int          errors;
  int          hdr_errors;
  int          hdr_count;
  int          wb_words;
  int          err_at_open;
  int          tests_passed;
  int          tests_failed;
  logic        bp_en;
  logic        wb_check_en;
  logic [3:0]  wr_left;
  logic [10:0] wr_blk;
  logic        wr_ofs;
  logic [3:0]  wr_cord;
  logic        wr_pending;

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  vcache_tile vcache_tile_i (
    .clk_i         (clk_i)
    ,.rst_n_i      (rst_n_i)
    ,.rst_n_o      (rst_n_o)
    ,.req_v_i      (req_v_i)
    ,.req_op_i     (req_op_i)
    ,.req_addr_i   (req_addr_i)
    ,.req_data_i   (req_data_i)
    ,.req_ready_o  (req_ready_o)
    ,.resp_v_o     (resp_v_o)
    ,.resp_data_o  (resp_data_o)
    ,.resp_ready_i (resp_ready_i)
    ,.wh_v_o       (wh_v_o)
    ,.wh_flit_o    (wh_flit_o)
    ,.wh_ready_i   (wh_ready_i)
    ,.wh_v_i       (wh_v_i)
    ,.wh_flit_i    (wh_flit_i)
    ,.wh_ready_o   (wh_ready_o)
    ,.global_x_i   (global_x_i)
    ,.global_y_i   (global_y_i)
    ,.global_x_o   (global_x_o)
    ,.global_y_o   (global_y_o)
  );

  // preload pattern, every address bit shows up
  function automatic logic [31:0] fill_word(input logic [11:0] a);
    return {4'hc, a, 4'h3, a ^ 12'h5a5};
  endfunction

  // stores answer zero, loads see the latest store in program order
  function automatic logic [31:0] expected_resp(input mc_op_e op, input logic [11:0] a);
    return (op == MC_STORE) ? 32'h0 : golden[a];
  endfunction

  task automatic note_mismatch(input string test, input string field, input logic [31:0] exp,
                               input logic [31:0] act, input logic is_hdr);
    $display("mismatch %s: %s expected %h actual %h", test, field, exp, act);
    if (is_hdr) begin
      hdr_errors++;
    end else begin
      errors++;
    end
  endtask

  task automatic issue(input mc_op_e op, input logic [11:0] a, input logic [31:0] d);
    @(posedge clk_i);
    req_v_i    <= 1'b1;
    req_op_i   <= op;
    req_addr_i <= a;
    req_data_i <= d;
    do @(posedge clk_i); while (req_ready_o !== 1'b1);
    req_v_i <= 1'b0;
    exp_q.push_back(expected_resp(op, a));
    if (op == MC_STORE) begin
      golden[a] = d;
    end
  endtask

  task automatic open_test(input string name);
    cur_test    = name;
    err_at_open = errors;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(posedge clk_i);
  endtask

  task automatic close_test();
    drain();
    if (errors == err_at_open) begin
      tests_passed++;
      $display("test %s: pass", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d errors", cur_test, errors - err_at_open);
    end
  endtask

  // cid from our coordinates, cord from the missing block's top bit
  task automatic check_header(input wh_hdr_s h);
    logic [1:0] exp_cid;
    logic [3:0] exp_cord;
    exp_cid  = {~MY_Y[3], MY_X[0]};
    exp_cord = {4{h.addr[10]}};
    hdr_count++;
    if (h.cid !== exp_cid) begin
      note_mismatch("header_fields", "cid", exp_cid, h.cid, 1'b1);
    end
    if (h.op == WH_WRITE) begin
      if (h.len !== 4'(`VC_BLOCK_WORDS)) begin
        note_mismatch("header_fields", "write len", `VC_BLOCK_WORDS, h.len, 1'b1);
      end
      wr_cord    = h.cord;
      wr_pending = 1'b1;
    end else begin
      if (h.len !== 4'd0) begin
        note_mismatch("header_fields", "read len", 0, h.len, 1'b1);
      end
      if (h.cord !== exp_cord) begin
        note_mismatch("header_fields", "read cord", exp_cord, h.cord, 1'b1);
      end
      // write-back belongs to the same miss as the read after it
      if (wr_pending && (wr_cord !== h.cord)) begin
        note_mismatch("header_fields", "write cord", h.cord, wr_cord, 1'b1);
      end
      wr_pending = 1'b0;
    end
  endtask

  // wormhole memory model
  always @(posedge clk_i) begin
    if ((wh_v_o === 1'b1) && wh_ready_i) begin
      if (wr_left != 0) begin
        if (wb_check_en && (wh_flit_o !== golden[{wr_blk, wr_ofs}])) begin
          note_mismatch(cur_test, "evict word", golden[{wr_blk, wr_ofs}], wh_flit_o, 1'b0);
        end
        mem[{wr_blk, wr_ofs}] = wh_flit_o;
        wb_words++;
        wr_ofs  = wr_ofs + 1'b1;
        wr_left = wr_left - 1'b1;
      end else begin
        in_flit.data = wh_flit_o;
        check_header(in_flit.hdr);
        if (in_flit.hdr.op == WH_WRITE) begin
          wr_blk  = in_flit.hdr.addr[10:0];
          wr_ofs  = 1'b0;
          wr_left = in_flit.hdr.len;
        end else begin
          // reply header, then lowest word first
          reply_flit         = in_flit;
          reply_flit.hdr.len = `VC_BLOCK_WORDS;
          reply_q.push_back(reply_flit.data);
          reply_q.push_back(mem[{in_flit.hdr.addr[10:0], 1'b0}]);
          reply_q.push_back(mem[{in_flit.hdr.addr[10:0], 1'b1}]);
        end
      end
    end
    if (wh_v_i && (wh_ready_o === 1'b1)) begin
      void'(reply_q.pop_front());
    end
    wh_v_i     <= (reply_q.size() != 0);
    wh_flit_i  <= (reply_q.size() != 0) ? reply_q[0] : 32'h0;
    wh_ready_i <= bp_en ? ($urandom_range(0, 1) == 1) : 1'b1;
  end

  always @(posedge clk_i) begin
    resp_ready_i <= bp_en ? ($urandom_range(0, 1) == 1) : 1'b1;
  end

  // responses come back in request order
  always @(posedge clk_i) begin
    if ((resp_v_o === 1'b1) && resp_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("%s: a response arrived with no request outstanding", cur_test);
        errors++;
      end else begin
        exp_word = exp_q.pop_front();
        if (resp_data_o !== exp_word) begin
          note_mismatch(cur_test, "resp_data", exp_word, resp_data_o, 1'b0);
        end
      end
    end
  end

  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk_i);
    $display("watchdog: the run did not complete within %0d cycles", LIMIT_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    seed         = $urandom(32'h3ca5fde8);
    rst_n_i      = 1'b0;
    req_v_i      = 1'b0;
    req_op_i     = MC_LOAD;
    req_addr_i   = '0;
    req_data_i   = '0;
    resp_ready_i = 1'b0;
    wh_ready_i   = 1'b0;
    wh_v_i       = 1'b0;
    wh_flit_i    = '0;
    global_x_i   = MY_X;
    global_y_i   = MY_Y;
    errors       = 0;
    hdr_errors   = 0;
    hdr_count    = 0;
    wb_words     = 0;
    tests_passed = 0;
    tests_failed = 0;
    bp_en        = 1'b0;
    wb_check_en  = 1'b0;
    wr_left      = '0;
    wr_blk       = '0;
    wr_ofs       = 1'b0;
    wr_cord      = '0;
    wr_pending   = 1'b0;
    for (int a = 0; a < 4096; a++) begin
      mem[a]    = fill_word(12'(a));
      golden[a] = fill_word(12'(a));
    end

    open_test("reset_coords");
    repeat (3) @(posedge clk_i);
    if (rst_n_o !== 1'b0) begin
      $display("reset_coords: rst_n_o is not low while reset is held");
      errors++;
    end
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    if (rst_n_o !== 1'b0) begin
      $display("reset_coords: rst_n_o rose without the one cycle delay");
      errors++;
    end
    @(posedge clk_i);
    if (rst_n_o !== 1'b1) begin
      note_mismatch(cur_test, "rst_n_o", 1, rst_n_o, 1'b0);
    end
    // req_ready_o stays low for the first cycle out of reset
    if ((resp_v_o !== 1'b0) || (wh_v_o !== 1'b0) || (req_ready_o !== 1'b0)) begin
      $display("reset_coords: a valid or ready output is high right after reset");
      errors++;
    end
    for (int y = 0; y < 16; y++) begin
      global_x_i <= 4'(15 - y);
      global_y_i <= 4'(y);
      @(posedge clk_i);
      if (global_x_o !== 4'(15 - y)) begin
        note_mismatch(cur_test, "global_x_o", 15 - y, global_x_o, 1'b0);
      end
      if (global_y_o !== 4'((y + 1) % 16)) begin
        note_mismatch(cur_test, "global_y_o", (y + 1) % 16, global_y_o, 1'b0);
      end
    end
    global_x_i <= MY_X;
    global_y_i <= MY_Y;
    close_test();

    open_test("read_miss");
    issue(MC_LOAD, 12'h0a4, 32'h0);
    issue(MC_LOAD, 12'h8b3, 32'h0);
    close_test();

    open_test("store_load");
    issue(MC_STORE, 12'h136, $urandom);
    issue(MC_LOAD, 12'h136, 32'h0);
    issue(MC_STORE, 12'h137, $urandom);
    issue(MC_LOAD, 12'h137, 32'h0);
    close_test();

    // same set, two tags, both lines end up dirty once
    open_test("writeback");
    wb_check_en = 1'b1;
    wb_words    = 0;
    issue(MC_STORE, 12'h210, $urandom);
    issue(MC_STORE, 12'h410, $urandom);
    issue(MC_LOAD, 12'h210, 32'h0);
    issue(MC_LOAD, 12'h211, 32'h0);
    issue(MC_LOAD, 12'h410, 32'h0);
    drain();
    if (wb_words !== 4) begin
      note_mismatch(cur_test, "write-back words", 4, wb_words, 1'b0);
    end
    wb_check_en = 1'b0;
    close_test();

    open_test("random_bp");
    bp_en = 1'b1;
    repeat (200) begin
      issue(($urandom_range(0, 1) == 1) ? MC_STORE : MC_LOAD, 12'($urandom) & 12'h83f,
            $urandom);
    end
    close_test();
    bp_en = 1'b0;

    cur_test = "header_fields";
    if (hdr_count == 0) begin
      $display("header_fields: no wormhole header was seen");
      hdr_errors++;
    end
    if (hdr_errors == 0) begin
      tests_passed++;
      $display("test header_fields: pass, %0d headers checked", hdr_count);
    end else begin
      tests_failed++;
      $display("test header_fields: fail, %0d errors", hdr_errors);
    end

    $display("tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
             errors + hdr_errors);
    if (tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* vc_cache.sv */
`timescale 1ns/1ps
`include "vc_consts.svh"

module vc_cache
  import vc_mc_pkg::*;
(
  input  logic        clk_i
  , input  logic        rst_n_i
  , cache_req_if.cache  req
  , cache_dma_if.cache  dma
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_EVICT,
    ST_FILL,
    ST_RESPOND
  } state_e;

  state_e                 state_r;
  cache_req_s             req_r;
  logic [`VC_TAG_W-1:0]   tag_r [`VC_SETS];
  logic [`VC_SETS-1:0]    valid_r;
  logic [`VC_SETS-1:0]    dirty_r;
  logic [`VC_DATA_W-1:0]  data_r [`VC_SETS][`VC_BLOCK_WORDS];
  logic                   pkt_sent_r;
  logic [`VC_OFS_W-1:0]   cnt_r;

  logic [`VC_IDX_W-1:0]   idx;
  logic [`VC_OFS_W-1:0]   ofs;
  logic [`VC_TAG_W-1:0]   tag;
  logic                   hit;
  logic                   serve;
  logic                   cnt_last;

  assign idx      = req_r.addr[`VC_OFS_W +: `VC_IDX_W];
  assign ofs      = req_r.addr[`VC_OFS_W-1:0];
  assign tag      = req_r.addr[`VC_ADDR_W-1 -: `VC_TAG_W];
  assign hit      = valid_r[idx] && (tag_r[idx] == tag);
  assign cnt_last = (cnt_r == `VC_OFS_W'(`VC_BLOCK_WORDS - 1));

  // a hit in lookup answers at once, after a fill the line always hits
  assign serve = ((state_r == ST_LOOKUP) || (state_r == ST_RESPOND)) && hit;

  assign req.req_ready = (state_r == ST_IDLE);
  assign req.resp_v    = serve;
  assign req.resp_data = (req_r.op == MC_STORE) ? '0 : data_r[idx][ofs];

  // packet goes first, then words for an eviction
  assign dma.pkt_v      = ((state_r == ST_EVICT) || (state_r == ST_FILL)) && !pkt_sent_r;
  assign dma.pkt_write  = (state_r == ST_EVICT);
  assign dma.pkt_addr   = (state_r == ST_EVICT) ? {tag_r[idx], idx} : {tag, idx};
  assign dma.evict_v    = (state_r == ST_EVICT) && pkt_sent_r;
  assign dma.evict_data = data_r[idx][cnt_r];
  assign dma.fill_ready = (state_r == ST_FILL) && pkt_sent_r;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r    <= ST_IDLE;
      pkt_sent_r <= 1'b0;
      cnt_r      <= '0;
      valid_r    <= '0;
      dirty_r    <= '0;
    end else begin
      case (state_r)
        ST_IDLE: begin
          if (req.req_v) begin
            state_r <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          if (!hit) begin
            state_r <= (valid_r[idx] && dirty_r[idx]) ? ST_EVICT : ST_FILL;
          end
        end
        ST_EVICT: begin
          if (dma.pkt_v && dma.pkt_yumi) begin
            pkt_sent_r <= 1'b1;
          end
          if (dma.evict_v && dma.evict_yumi) begin
            cnt_r <= cnt_r + 1'b1;
            if (cnt_last) begin
              pkt_sent_r <= 1'b0;
              state_r    <= ST_FILL;
            end
          end
        end
        ST_FILL: begin
          if (dma.pkt_v && dma.pkt_yumi) begin
            pkt_sent_r <= 1'b1;
          end
          if (dma.fill_v && dma.fill_ready) begin
            cnt_r <= cnt_r + 1'b1;
            if (cnt_last) begin
              pkt_sent_r     <= 1'b0;
              valid_r[idx]   <= 1'b1;
              dirty_r[idx]   <= 1'b0;
              state_r        <= ST_RESPOND;
            end
          end
        end
        default: begin
          state_r <= state_r;
        end
      endcase
      // response taken, store marks the line
      if (serve && req.resp_yumi) begin
        state_r <= ST_IDLE;
        if (req_r.op == MC_STORE) begin
          dirty_r[idx] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req.req_v && req.req_ready) begin
      req_r <= req.req;
    end
    if (dma.fill_v && dma.fill_ready) begin
      data_r[idx][cnt_r] <= dma.fill_data;
      if (cnt_last) begin
        tag_r[idx] <= tag;
      end
    end
    if (serve && req.resp_yumi && (req_r.op == MC_STORE)) begin
      data_r[idx][ofs] <= req_r.data;
    end
  end

  // fill words only come while the read packet is outstanding
  fill_expected_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dma.fill_v |-> dma.fill_ready);

endmodule

/* vc_consts.svh */
`ifndef VC_CONSTS_SVH
`define VC_CONSTS_SVH

// manycore side word and address sizes
`define VC_DATA_W 32
`define VC_ADDR_W 12
`define VC_X_W 4
`define VC_Y_W 4

// cache geometry, direct mapped
`define VC_BLOCK_WORDS 2
`define VC_SETS 8
`define VC_OFS_W 1
`define VC_IDX_W 3
`define VC_TAG_W 8
`define VC_BADDR_W 11

// wormhole fields, header addr takes what is left of the flit
`define VC_WH_CORD_W 4
`define VC_WH_LEN_W 4
`define VC_WH_CID_W 2
`define VC_WH_FLIT_W 32
`define VC_WH_ADDR_W 21

`endif

/* vc_dma_to_wh.sv */
`timescale 1ns/1ps
`include "vc_consts.svh"

module vc_dma_to_wh
  import vc_wh_pkg::*;
(
  input  logic                      clk_i
  , input  logic                      rst_n_i
  , cache_dma_if.wh                   dma
  , input  logic                      east_not_west_i
  , input  logic [`VC_WH_CID_W-2:0]   my_x_i
  , input  logic                      my_y_msb_i
  , output logic                      wh_v_o
  , output wh_flit_u                  wh_flit_o
  , input  logic                      wh_ready_i
  , input  logic                      wh_v_i
  , input  wh_flit_u                  wh_flit_i
  , output logic                      wh_ready_o
);

  typedef enum logic [1:0] {TX_IDLE, TX_HDR, TX_DATA} tx_state_e;
  typedef enum logic {RX_HDR, RX_DATA} rx_state_e;

  tx_state_e            tx_state_r;
  rx_state_e            rx_state_r;
  wh_hdr_s              hdr_r;
  logic [`VC_OFS_W-1:0] tx_cnt_r;
  logic [`VC_OFS_W-1:0] rx_cnt_r;

  // send side
  assign dma.pkt_yumi   = (tx_state_r == TX_IDLE) && dma.pkt_v;
  assign dma.evict_yumi = (tx_state_r == TX_DATA) && dma.evict_v && wh_ready_i;
  assign wh_v_o         = (tx_state_r == TX_HDR) || ((tx_state_r == TX_DATA) && dma.evict_v);

  always_comb begin
    if (tx_state_r == TX_DATA) begin
      wh_flit_o.data = dma.evict_data;
    end else begin
      wh_flit_o.hdr = hdr_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tx_state_r <= TX_IDLE;
      tx_cnt_r   <= '0;
    end else begin
      case (tx_state_r)
        TX_IDLE: begin
          if (dma.pkt_yumi) begin
            tx_state_r <= TX_HDR;
          end
        end
        TX_HDR: begin
          if (wh_ready_i) begin
            tx_state_r <= (hdr_r.op == WH_WRITE) ? TX_DATA : TX_IDLE;
          end
        end
        default: begin
          if (dma.evict_yumi) begin
            tx_cnt_r <= tx_cnt_r + 1'b1;
            if (tx_cnt_r == `VC_OFS_W'(`VC_BLOCK_WORDS - 1)) begin
              tx_state_r <= TX_IDLE;
            end
          end
        end
      endcase
    end
  end

  // cord is all ones for east, cid is {south/north, x low bit}
  always_ff @(posedge clk_i) begin
    if (dma.pkt_yumi) begin
      hdr_r.addr <= {{(`VC_WH_ADDR_W - `VC_BADDR_W){1'b0}}, dma.pkt_addr};
      hdr_r.op   <= dma.pkt_write ? WH_WRITE : WH_READ;
      hdr_r.cid  <= {~my_y_msb_i, my_x_i};
      hdr_r.cord <= {`VC_WH_CORD_W{east_not_west_i}};
      hdr_r.len  <= dma.pkt_write ? `VC_WH_LEN_W'(`VC_BLOCK_WORDS) : '0;
    end
  end

  // receive side, reply header is dropped
  assign wh_ready_o     = (rx_state_r == RX_HDR) || dma.fill_ready;
  assign dma.fill_v     = (rx_state_r == RX_DATA) && wh_v_i;
  assign dma.fill_data  = wh_flit_i.data;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rx_state_r <= RX_HDR;
      rx_cnt_r   <= '0;
    end else if (rx_state_r == RX_HDR) begin
      if (wh_v_i) begin
        rx_state_r <= RX_DATA;
      end
    end else if (dma.fill_v && dma.fill_ready) begin
      rx_cnt_r <= rx_cnt_r + 1'b1;
      if (rx_cnt_r == `VC_OFS_W'(`VC_BLOCK_WORDS - 1)) begin
        rx_state_r <= RX_HDR;
      end
    end
  end

  reply_len_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (rx_state_r == RX_HDR) && wh_v_i && wh_ready_o
      |-> wh_flit_i.hdr.len == `VC_WH_LEN_W'(`VC_BLOCK_WORDS));

endmodule

/* vc_link_to_cache.sv */
`timescale 1ns/1ps
`include "vc_consts.svh"

module vc_link_to_cache
  import vc_mc_pkg::*;
(
  input  logic                  clk_i
  , input  logic                  rst_n_i
  , input  logic                  req_v_i
  , input  mc_op_e                req_op_i
  , input  logic [`VC_ADDR_W-1:0] req_addr_i
  , input  logic [`VC_DATA_W-1:0] req_data_i
  , output logic                  req_ready_o
  , output logic                  resp_v_o
  , output logic [`VC_DATA_W-1:0] resp_data_o
  , input  logic                  resp_ready_i
  , cache_req_if.link             cache
  , output logic                  east_not_west_o
);

  logic                  init_r;
  logic                  req_full_r;
  logic                  resp_full_r;
  cache_req_s            req_r;
  logic [`VC_DATA_W-1:0] resp_data_r;
  logic                  east_not_west_r;

  // no new request while a response is still waiting
  assign req_ready_o = init_r & ~req_full_r & ~resp_full_r;

  assign cache.req_v     = req_full_r;
  assign cache.req       = req_r;
  assign cache.resp_yumi = cache.resp_v & ~resp_full_r;

  assign resp_v_o        = resp_full_r;
  assign resp_data_o     = resp_data_r;
  assign east_not_west_o = east_not_west_r;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      init_r      <= 1'b0;
      req_full_r  <= 1'b0;
      resp_full_r <= 1'b0;
    end else begin
      init_r <= 1'b1;
      if (req_v_i && req_ready_o) begin
        req_full_r <= 1'b1;
      end else if (cache.req_v && cache.req_ready) begin
        req_full_r <= 1'b0;
      end
      if (cache.resp_v && cache.resp_yumi) begin
        resp_full_r <= 1'b1;
      end else if (resp_v_o && resp_ready_i) begin
        resp_full_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_v_i && req_ready_o) begin
      req_r.op   <= req_op_i;
      req_r.addr <= req_addr_i;
      req_r.data <= req_data_i;
    end
    // destination follows the request the cache is working on
    if (cache.req_v && cache.req_ready) begin
      east_not_west_r <= req_r.addr[`VC_ADDR_W-1];
    end
    if (cache.resp_v && cache.resp_yumi) begin
      resp_data_r <= cache.resp_data;
    end
  end

  // an untaken cache response stays in place until the register frees up
  resp_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cache.resp_v && !cache.resp_yumi |=> cache.resp_v && $stable(cache.resp_data));

endmodule

/* vc_mc_pkg.sv */
`include "vc_consts.svh"

package vc_mc_pkg;

  // manycore request opcode
  typedef enum logic {
    MC_LOAD  = 1'b0,
    MC_STORE = 1'b1
  } mc_op_e;

  // one cache request, word addressed
  typedef struct packed {
    mc_op_e                op;
    logic [`VC_ADDR_W-1:0] addr;
    logic [`VC_DATA_W-1:0] data;
  } cache_req_s;

endpackage

/* vc_tile_if.sv */
`timescale 1ns/1ps
`include "vc_consts.svh"

// link adapter to cache, request and response channels
interface cache_req_if
  import vc_mc_pkg::*;
();
  logic                  req_v;
  cache_req_s            req;
  logic                  req_ready;
  logic                  resp_v;
  logic [`VC_DATA_W-1:0] resp_data;
  logic                  resp_yumi;

  modport link (output req_v, req, resp_yumi, input req_ready, resp_v, resp_data);
  modport cache (input req_v, req, resp_yumi, output req_ready, resp_v, resp_data);
endinterface

// cache to dma adapter, packet, fill and evict channels
interface cache_dma_if;
  logic                   pkt_v;
  logic                   pkt_write;
  logic [`VC_BADDR_W-1:0] pkt_addr;
  logic                   pkt_yumi;
  logic                   fill_v;
  logic [`VC_DATA_W-1:0]  fill_data;
  logic                   fill_ready;
  logic                   evict_v;
  logic [`VC_DATA_W-1:0]  evict_data;
  logic                   evict_yumi;

  modport cache (output pkt_v, pkt_write, pkt_addr, fill_ready, evict_v, evict_data,
                 input pkt_yumi, fill_v, fill_data, evict_yumi);
  modport wh (input pkt_v, pkt_write, pkt_addr, fill_ready, evict_v, evict_data,
              output pkt_yumi, fill_v, fill_data, evict_yumi);
endinterface

/* vc_wh_pkg.sv */
`include "vc_consts.svh"

package vc_wh_pkg;

  // dma opcode as carried in the header
  typedef enum logic {
    WH_READ  = 1'b0,
    WH_WRITE = 1'b1
  } wh_op_e;

  // len sits in the low bits of the flit
  typedef struct packed {
    logic [`VC_WH_ADDR_W-1:0] addr;
    wh_op_e                   op;
    logic [`VC_WH_CID_W-1:0]  cid;
    logic [`VC_WH_CORD_W-1:0] cord;
    logic [`VC_WH_LEN_W-1:0]  len;
  } wh_hdr_s;

  // first flit of a packet is a header, the rest are data words
  typedef union packed {
    wh_hdr_s                  hdr;
    logic [`VC_WH_FLIT_W-1:0] data;
  } wh_flit_u;

endpackage

/* vcache_tile.f */
+incdir+.
vc_mc_pkg.sv
vc_wh_pkg.sv
vc_tile_if.sv
vc_link_to_cache.sv
vc_cache.sv
vc_dma_to_wh.sv
vcache_tile.sv
tb_vcache_tile.sv

/* vcache_tile.sv */
`timescale 1ns/1ps
`include "vc_consts.svh"

module vcache_tile
  import vc_mc_pkg::*;
(
  input  logic                     clk_i
  , input  logic                     rst_n_i
  , output logic                     rst_n_o

  // manycore request port
  , input  logic                     req_v_i
  , input  mc_op_e                   req_op_i
  , input  logic [`VC_ADDR_W-1:0]    req_addr_i
  , input  logic [`VC_DATA_W-1:0]    req_data_i
  , output logic                     req_ready_o
  , output logic                     resp_v_o
  , output logic [`VC_DATA_W-1:0]    resp_data_o
  , input  logic                     resp_ready_i

  // wormhole link
  , output logic                     wh_v_o
  , output logic [`VC_WH_FLIT_W-1:0] wh_flit_o
  , input  logic                     wh_ready_i
  , input  logic                     wh_v_i
  , input  logic [`VC_WH_FLIT_W-1:0] wh_flit_i
  , output logic                     wh_ready_o

  // coordinates
  , input  logic [`VC_X_W-1:0]       global_x_i
  , input  logic [`VC_Y_W-1:0]       global_y_i
  , output logic [`VC_X_W-1:0]       global_x_o
  , output logic [`VC_Y_W-1:0]       global_y_o
);

  logic rst_r;
  logic east_not_west;

  // registered reset feeds every block and the next tile
  always_ff @(posedge clk_i) begin
    rst_r <= rst_n_i;
  end

  assign rst_n_o    = rst_r;
  assign global_x_o = global_x_i;
  assign global_y_o = global_y_i + `VC_Y_W'(1);

  cache_req_if req_if ();
  cache_dma_if dma_if ();

  vc_link_to_cache link_to_cache (
    .clk_i            (clk_i)
    ,.rst_n_i         (rst_r)
    ,.req_v_i         (req_v_i)
    ,.req_op_i        (req_op_i)
    ,.req_addr_i      (req_addr_i)
    ,.req_data_i      (req_data_i)
    ,.req_ready_o     (req_ready_o)
    ,.resp_v_o        (resp_v_o)
    ,.resp_data_o     (resp_data_o)
    ,.resp_ready_i    (resp_ready_i)
    ,.cache           (req_if.link)
    ,.east_not_west_o (east_not_west)
  );

  vc_cache cache (
    .clk_i    (clk_i)
    ,.rst_n_i (rst_r)
    ,.req     (req_if.cache)
    ,.dma     (dma_if.cache)
  );

  vc_dma_to_wh dma_to_wh (
    .clk_i            (clk_i)
    ,.rst_n_i         (rst_r)
    ,.dma             (dma_if.wh)
    ,.east_not_west_i (east_not_west)
    ,.my_x_i          (global_x_i[`VC_WH_CID_W-2:0])
    ,.my_y_msb_i      (global_y_i[`VC_Y_W-1])
    ,.wh_v_o          (wh_v_o)
    ,.wh_flit_o       (wh_flit_o)
    ,.wh_ready_i      (wh_ready_i)
    ,.wh_v_i          (wh_v_i)
    ,.wh_flit_i       (wh_flit_i)
    ,.wh_ready_o      (wh_ready_o)
  );

endmodule
